// ==== lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// depth of the data memory in 32-bit words, power of two
`define LSU_RAM_WORDS 256

// byte address bits decoded by the memory
`define LSU_ADDR_BITS ($clog2(`LSU_RAM_WORDS) + 2)

// cycles the memory holds its wait level after a strobe
`define LSU_WAIT_STATES 2

`endif

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // bus operations issued by the core
    typedef enum logic [2:0] {
        READB  = 3'b000,
        READBU = 3'b001,
        READH  = 3'b010,
        READHU = 3'b011,
        READW  = 3'b100,
        WRITEB = 3'b101,
        WRITEH = 3'b110,
        WRITEW = 3'b111
    } bus_op_e;

    // issue side FSM
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        ISSUE = 2'b01,
        WAIT  = 2'b10,
        DONE  = 2'b11
    } lsu_state_e;

    // request from the core
    typedef struct packed {
        bus_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    // command toward the memory
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        strobe;
        logic        write;
        // neither size flag set means a byte access
        logic        halfword;
        logic        fullword;
    } bus_cmd_t;

    // result returned with done
    typedef struct packed {
        logic [31:0] rdata;
        logic        misaligned;
    } lsu_resp_t;

endpackage

// ==== lsu_issue.sv ====
module lsu_issue (
    input  logic               I_clk,
    input  logic               reset,
    input  logic               req,
    input  lsu_pkg::lsu_req_t  req_data,
    output logic               busy,
    output logic               done,
    output lsu_pkg::lsu_resp_t resp,
    output logic               bus_en,
    output lsu_pkg::bus_op_e   bus_op,
    output logic [31:0]        bus_addr,
    output logic [31:0]        bus_wdata,
    input  logic               bus_busy,
    input  logic [31:0]        bus_rdata
);

    import lsu_pkg::*;

    lsu_state_e state;
    lsu_req_t   req_q;
    lsu_resp_t  resp_q;
    logic       bus_en_q;
    logic       misaligned;
    logic       is_read;

    // alignment check on the incoming request
    always_comb begin
        case (req_data.op)
            READH, READHU, WRITEH: begin
                misaligned = req_data.addr[0];
            end
            READW, WRITEW: begin
                misaligned = |req_data.addr[1:0];
            end
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    assign is_read = !(req_q.op inside {WRITEB, WRITEH, WRITEW});

    always_ff @(posedge I_clk) begin
        if (reset) begin
            state    <= IDLE;
            bus_en_q <= 1'b0;
        end else begin
            // strobe lasts a single cycle
            bus_en_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        if (misaligned) begin
                            state <= DONE;
                        end else begin
                            state    <= ISSUE;
                            bus_en_q <= 1'b1;
                        end
                    end
                end
                ISSUE: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (!bus_busy) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request and result registers
    always_ff @(posedge I_clk) begin
        if (state == IDLE && req) begin
            req_q <= req_data;
            if (misaligned) begin
                resp_q <= '{rdata: 32'h0, misaligned: 1'b1};
            end
        end
        if (state == WAIT && !bus_busy) begin
            // writes report zero
            resp_q <= '{rdata: is_read ? bus_rdata : 32'h0, misaligned: 1'b0};
        end
    end

    // the memory clear sweep after reset also holds the core off
    assign busy      = (state != IDLE) || bus_busy;
    assign done      = (state == DONE);
    assign resp      = resp_q;
    assign bus_en    = bus_en_q;
    assign bus_op    = req_q.op;
    assign bus_addr  = req_q.addr;
    assign bus_wdata = req_q.wdata;

    a_strobe_in_issue: assert property (
        @(posedge I_clk) disable iff (reset) bus_en |-> state == ISSUE
    );

    a_no_req_when_busy: assert property (
        @(posedge I_clk) disable iff (reset) req |-> !busy
    );

endmodule

// ==== bus_op_decode.sv ====
module bus_op_decode (
    input  logic              I_clk,
    input  logic              reset,
    input  logic              en,
    input  lsu_pkg::bus_op_e  op,
    input  logic [31:0]       addr,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata,
    output logic              busy,
    output lsu_pkg::bus_cmd_t cmd,
    input  logic [31:0]       bus_rdata_raw,
    input  logic              bus_wait
);

    import lsu_pkg::*;

    logic    halfword;
    logic    fullword;
    logic    write;
    bus_op_e last_op;

    // access size
    always_comb begin
        case (op)
            READH, READHU, WRITEH: begin
                halfword = 1'b1;
                fullword = 1'b0;
            end
            READW, WRITEW: begin
                halfword = 1'b0;
                fullword = 1'b1;
            end
            default: begin
                halfword = 1'b0;
                fullword = 1'b0;
            end
        endcase
    end

    // direction
    always_comb begin
        case (op)
            WRITEB, WRITEH, WRITEW: begin
                write = 1'b1;
            end
            default: begin
                write = 1'b0;
            end
        endcase
    end

    assign cmd = '{
        addr:     addr,
        data:     wdata,
        strobe:   en,
        write:    write,
        halfword: halfword,
        fullword: fullword
    };

    assign busy = bus_wait;

    // the issue side may present a new op before the read data returns
    always_ff @(posedge I_clk) begin
        if (reset) begin
            last_op <= READW;
        end else if (en) begin
            last_op <= op;
        end
    end

    // extend the low lane according to the op that fetched it
    always_comb begin
        case (last_op)
            READB: begin
                rdata = {{24{bus_rdata_raw[7]}}, bus_rdata_raw[7:0]};
            end
            READBU: begin
                rdata = {24'h0, bus_rdata_raw[7:0]};
            end
            READH: begin
                rdata = {{16{bus_rdata_raw[15]}}, bus_rdata_raw[15:0]};
            end
            READHU: begin
                rdata = {16'h0, bus_rdata_raw[15:0]};
            end
            default: begin
                rdata = bus_rdata_raw;
            end
        endcase
    end

    a_one_size: assert property (
        @(posedge I_clk) disable iff (reset) !(cmd.halfword && cmd.fullword)
    );

endmodule

// ==== data_ram.sv ====
`include "lsu_macros.svh"

module data_ram (
    input  logic              I_clk,
    input  logic              reset,
    input  lsu_pkg::bus_cmd_t cmd,
    output logic [31:0]       rdata,
    output logic              wait_out
);

    localparam int WIDX_W = `LSU_ADDR_BITS - 2;
    localparam int WAIT_W = $clog2(`LSU_WAIT_STATES + 1);

    logic [31:0]       mem [`LSU_RAM_WORDS];
    logic [WIDX_W-1:0] widx;
    logic [3:0]        wr_be;
    logic [31:0]       wr_word;
    logic [31:0]       rd_word;
    logic [31:0]       rd_shifted;
    logic [31:0]       rdata_q;
    logic [WAIT_W-1:0] wait_cnt;
    logic [WIDX_W-1:0] sweep_idx;
    logic              sweep_active;

    assign widx = cmd.addr[`LSU_ADDR_BITS-1:2];

    // replicate the low bus bits onto every lane and pick the lanes to write
    always_comb begin
        if (cmd.fullword) begin
            wr_be   = 4'b1111;
            wr_word = cmd.data;
        end else if (cmd.halfword) begin
            wr_be   = cmd.addr[1] ? 4'b1100 : 4'b0011;
            wr_word = {2{cmd.data[15:0]}};
        end else begin
            wr_be   = 4'b0001 << cmd.addr[1:0];
            wr_word = {4{cmd.data[7:0]}};
        end
    end

    // move the addressed lane down to the low bits
    assign rd_word = mem[widx];

    always_comb begin
        if (cmd.fullword) begin
            rd_shifted = rd_word;
        end else if (cmd.halfword) begin
            rd_shifted = rd_word >> {cmd.addr[1], 4'b0000};
        end else begin
            rd_shifted = rd_word >> {cmd.addr[1:0], 3'b000};
        end
    end

    // clear sweep runs one word per cycle after reset
    always_ff @(posedge I_clk) begin
        if (reset) begin
            sweep_active <= 1'b1;
            sweep_idx    <= '0;
        end else if (sweep_active) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                sweep_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (sweep_active) begin
            mem[sweep_idx] <= 32'h0;
        end else if (cmd.strobe && cmd.write) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) begin
                    mem[widx][i*8 +: 8] <= wr_word[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (cmd.strobe && !cmd.write) begin
            rdata_q <= rd_shifted;
        end
    end

    // wait level for a fixed number of cycles after each strobe
    always_ff @(posedge I_clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (cmd.strobe) begin
            wait_cnt <= WAIT_W'(`LSU_WAIT_STATES);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign wait_out = sweep_active || (wait_cnt != '0);
    assign rdata    = rdata_q;

    a_no_strobe_in_wait: assert property (
        @(posedge I_clk) disable iff (reset) cmd.strobe |-> !wait_out
    );

endmodule

// ==== lsu_top.sv ====
module lsu_top (
    input  logic               I_clk,
    input  logic               reset,
    input  logic               req,
    input  lsu_pkg::lsu_req_t  req_data,
    output logic               busy,
    output logic               done,
    output lsu_pkg::lsu_resp_t resp
);

    import lsu_pkg::*;

    logic        bus_en;
    bus_op_e     bus_op;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_busy;
    logic [31:0] bus_rdata;
    bus_cmd_t    cmd;
    logic [31:0] bus_rdata_raw;
    logic        bus_wait;

    lsu_issue u_issue (
        .I_clk     (I_clk),
        .reset     (reset),
        .req       (req),
        .req_data  (req_data),
        .busy      (busy),
        .done      (done),
        .resp      (resp),
        .bus_en    (bus_en),
        .bus_op    (bus_op),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_busy  (bus_busy),
        .bus_rdata (bus_rdata)
    );

    bus_op_decode u_decode (
        .I_clk         (I_clk),
        .reset         (reset),
        .en            (bus_en),
        .op            (bus_op),
        .addr          (bus_addr),
        .wdata         (bus_wdata),
        .rdata         (bus_rdata),
        .busy          (bus_busy),
        .cmd           (cmd),
        .bus_rdata_raw (bus_rdata_raw),
        .bus_wait      (bus_wait)
    );

    data_ram u_ram (
        .I_clk    (I_clk),
        .reset    (reset),
        .cmd      (cmd),
        .rdata    (bus_rdata_raw),
        .wait_out (bus_wait)
    );

endmodule

// ==== tb_lsu_top.sv ====
`include "lsu_macros.svh"

module tb_lsu_top;

    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int MEM_BYTES = 4 * `LSU_RAM_WORDS;
    localparam int LIMIT     = 1000;
    localparam int BURST     = 8;

    // one directed request with its expected response
    typedef struct packed {
        lsu_req_t    req;
        logic [31:0] rdata;
        logic        misaligned;
    } step_t;

    logic      I_clk;
    logic      reset;
    logic      req;
    lsu_req_t  req_data;
    logic      busy;
    logic      done;
    lsu_resp_t resp;

    logic [7:0]  ref_mem [MEM_BYTES];
    step_t       steps [$];
    logic [31:0] burst_addr [BURST];
    logic [31:0] lcg_state;
    int          errors;
    int          timeouts;

    lsu_top u_dut (.*);

    always begin
        #10 I_clk = ~I_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte-wide memory model, byte lane n of a word sits at address offset n
    function automatic logic [31:0] model_access(input lsu_req_t r);
        int a;
        a = int'(r.addr % MEM_BYTES);
        if ((r.op inside {READH, READHU, WRITEH} && r.addr[0]) ||
            (r.op inside {READW, WRITEW} && r.addr[1:0] != 2'b00)) begin
            return 32'h0;
        end
        case (r.op)
            WRITEB: begin
                ref_mem[a] = r.wdata[7:0];
            end
            WRITEH: begin
                ref_mem[a]     = r.wdata[7:0];
                ref_mem[a + 1] = r.wdata[15:8];
            end
            WRITEW: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[a + i] = r.wdata[i*8 +: 8];
                end
            end
            READB:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
            READBU: return {24'h0, ref_mem[a]};
            READH:  return {{16{ref_mem[a + 1][7]}}, ref_mem[a + 1], ref_mem[a]};
            READHU: return {16'h0, ref_mem[a + 1], ref_mem[a]};
            default: return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
        endcase
        return 32'h0;
    endfunction

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < LIMIT) begin
            @(negedge I_clk);
            n++;
        end
        if (busy !== 1'b0) begin
            timeouts++;
            $display("timeout: the DUT stayed busy and never accepted a request");
        end
    endtask

    // done is a single pulse and the core may issue again next cycle
    task automatic check_released();
        @(negedge I_clk);
        check_flag("done", 1'b0, done);
        check_flag("busy", 1'b0, busy);
    endtask

    task automatic run_request(input lsu_req_t r, output lsu_resp_t got);
        int n;
        @(posedge I_clk);
        req      <= 1'b1;
        req_data <= r;
        // request sits in the cycle right after the previous done
        check_released();
        @(posedge I_clk);
        req <= 1'b0;
        @(negedge I_clk);
        // accepted requests raise busy right away
        check_flag("busy", 1'b1, busy);
        n = 0;
        while (done !== 1'b1 && n < LIMIT) begin
            @(negedge I_clk);
            n++;
        end
        if (done !== 1'b1) begin
            timeouts++;
            $display("timeout: no done for %s at address %h", r.op.name(), r.addr);
        end
        got = resp;
    endtask

    task automatic apply_and_check(input lsu_req_t r, input logic [31:0] exp_rdata,
                                   input logic exp_mis);
        lsu_resp_t got;
        run_request(r, got);
        check_data("resp.rdata", exp_rdata, got.rdata);
        check_flag("resp.misaligned", exp_mis, got.misaligned);
    endtask

    task automatic add_step(input bus_op_e s_op, input logic [31:0] s_addr,
                            input logic [31:0] s_wdata, input logic [31:0] s_rdata,
                            input logic s_mis);
        steps.push_back('{req: '{op: s_op, addr: s_addr, wdata: s_wdata},
                          rdata: s_rdata, misaligned: s_mis});
    endtask

    initial begin
        lsu_req_t r;
        I_clk    = 1'b0;
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        errors   = 0;
        timeouts = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end

        // word write and read back
        add_step(WRITEW, 32'h010, 32'hdeadbeef, 32'h0, 1'b0);
        add_step(READW,  32'h010, 32'h0, 32'hdeadbeef, 1'b0);
        // byte lanes assembled into one word, upper write bits ignored
        add_step(WRITEB, 32'h020, 32'haaaaaa11, 32'h0, 1'b0);
        add_step(WRITEB, 32'h021, 32'h55555522, 32'h0, 1'b0);
        add_step(WRITEB, 32'h022, 32'hffffff33, 32'h0, 1'b0);
        add_step(WRITEB, 32'h023, 32'h00000044, 32'h0, 1'b0);
        add_step(READW,  32'h020, 32'h0, 32'h44332211, 1'b0);
        add_step(READB,  32'h022, 32'h0, 32'h00000033, 1'b0);
        // sign and zero extension
        add_step(WRITEW, 32'h030, 32'h9abc80f1, 32'h0, 1'b0);
        add_step(READB,  32'h030, 32'h0, 32'hfffffff1, 1'b0);
        add_step(READBU, 32'h030, 32'h0, 32'h000000f1, 1'b0);
        add_step(READB,  32'h031, 32'h0, 32'hffffff80, 1'b0);
        add_step(READBU, 32'h033, 32'h0, 32'h0000009a, 1'b0);
        add_step(READH,  32'h030, 32'h0, 32'hffff80f1, 1'b0);
        add_step(READHU, 32'h032, 32'h0, 32'h00009abc, 1'b0);
        add_step(READH,  32'h032, 32'h0, 32'hffff9abc, 1'b0);
        add_step(WRITEH, 32'h036, 32'h1234c001, 32'h0, 1'b0);
        add_step(READW,  32'h034, 32'h0, 32'hc0010000, 1'b0);
        add_step(READH,  32'h036, 32'h0, 32'hffffc001, 1'b0);
        // misaligned accesses never reach memory
        add_step(READH,  32'h031, 32'h0, 32'h0, 1'b1);
        add_step(WRITEH, 32'h011, 32'h00001234, 32'h0, 1'b1);
        add_step(READW,  32'h012, 32'h0, 32'h0, 1'b1);
        add_step(WRITEW, 32'h013, 32'h55555555, 32'h0, 1'b1);
        add_step(WRITEW, 32'h016, 32'h66666666, 32'h0, 1'b1);
        add_step(READW,  32'h010, 32'h0, 32'hdeadbeef, 1'b0);
        add_step(READW,  32'h014, 32'h0, 32'h0, 1'b0);

        repeat (16) @(posedge I_clk);
        reset <= 1'b0;
        // memory clear sweep keeps busy high for a while
        wait_idle();

        foreach (steps[i]) begin
            void'(model_access(steps[i].req));
            apply_and_check(steps[i].req, steps[i].rdata, steps[i].misaligned);
        end

        // random word burst, read back in reverse order
        lcg_state = 32'd82;
        for (int i = 0; i < BURST; i++) begin
            lcg_state     = lcg_next(lcg_state);
            burst_addr[i] = ((lcg_state >> 8) % MEM_BYTES) & ~32'h3;
            lcg_state     = lcg_next(lcg_state);
            r = '{op: WRITEW, addr: burst_addr[i], wdata: lcg_state};
            apply_and_check(r, model_access(r), 1'b0);
        end
        for (int i = BURST - 1; i >= 0; i--) begin
            r = '{op: READW, addr: burst_addr[i], wdata: 32'h0};
            apply_and_check(r, model_access(r), 1'b0);
        end
        check_released();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
lsu_pkg.sv
lsu_issue.sv
bus_op_decode.sv
data_ram.sv
lsu_top.sv
tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_issue.sv
      - bus_op_decode.sv
      - data_ram.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu_top.sv
